// ==== verilog/sort_params.svh ====
`ifndef SORT_PARAMS_SVH
`define SORT_PARAMS_SVH

// width of the payload word carried by each cell.
`define DATA_WIDTH 8

// power of two number of switch ports.
`define PORT_NUB_TOTAL 8

`endif

// ==== verilog/sort_pkg.sv ====
`include "sort_params.svh"

package sort_pkg;

    localparam int port_w = $clog2(`PORT_NUB_TOTAL);  // width of a port index.
    localparam int key_w  = port_w + 1;

    typedef struct packed {
        logic                   valid;
        logic [port_w-1:0]      src;
        logic [port_w-1:0]      dst;
        logic [`DATA_WIDTH-1:0] data;
    } cell_t;

    // one cell per switch port, index 0 is port 0.
    typedef cell_t [`PORT_NUB_TOTAL-1:0] cell_vec_t;

    typedef logic [port_w:0] drop_cnt_t;

    // invalid cells get the high key bit so they sort last.
    function automatic logic [key_w-1:0] sort_key(input cell_t c);
        return {~c.valid, c.dst};
    endfunction

endpackage

// ==== verilog/exchange_unit.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module exchange_unit (
    input  logic            clk,
    input  logic            rst,
    input  sort_pkg::cell_t a_in,
    input  sort_pkg::cell_t b_in,
    output sort_pkg::cell_t lo_out,
    output sort_pkg::cell_t hi_out
);
    import sort_pkg::*;

    logic [key_w-1:0] key_a;
    logic [key_w-1:0] key_b;
    logic             swap;

    assign key_a = sort_key(a_in);
    assign key_b = sort_key(b_in);
    assign swap  = key_b < key_a;  // ties keep a on the low side.

    always_ff @(posedge clk) begin
        if (rst) begin
            lo_out <= '0;
            hi_out <= '0;
        end else if (swap) begin
            lo_out <= b_in;
            hi_out <= a_in;
        end else begin
            lo_out <= a_in;
            hi_out <= b_in;
        end
    end

    // registered pair must leave in key order once out of reset.
    a_pair_ordered : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> sort_key(lo_out) <= sort_key(hi_out)
    ) else $error("exchange_unit: lo_out key above hi_out key.");

endmodule

// ==== verilog/merge_module.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module merge_module #(
    parameter int PORT_NUB = `PORT_NUB_TOTAL
) (
    input  logic                           clk,
    input  logic                           rst,
    input  sort_pkg::cell_t [PORT_NUB-1:0] port_in,
    output sort_pkg::cell_t [PORT_NUB-1:0] port_out
);
    import sort_pkg::*;

    generate
        if (PORT_NUB == 2) begin : g_base
            exchange_unit u_xchg (
                .clk    (clk),
                .rst    (rst),
                .a_in   (port_in[0]),
                .b_in   (port_in[1]),
                .lo_out (port_out[0]),
                .hi_out (port_out[1])
            );
        end else begin : g_rec
            cell_t [PORT_NUB/2-1:0] even_in;
            cell_t [PORT_NUB/2-1:0] odd_in;
            cell_t [PORT_NUB/2-1:0] even_out;
            cell_t [PORT_NUB/2-1:0] odd_out;
            cell_t [PORT_NUB-1:0]   mixed;
            cell_t                  first_q;
            cell_t                  last_q;

            // both halves stay sorted when split by index parity.
            for (genvar i = 0; i < PORT_NUB/2; i++) begin : g_split
                assign even_in[i]     = port_in[2*i];
                assign odd_in[i]      = port_in[2*i+1];
                assign mixed[2*i]     = even_out[i];
                assign mixed[2*i+1]   = odd_out[i];
            end

            merge_module #(.PORT_NUB(PORT_NUB/2)) u_even (
                .clk      (clk),
                .rst      (rst),
                .port_in  (even_in),
                .port_out (even_out)
            );

            merge_module #(.PORT_NUB(PORT_NUB/2)) u_odd (
                .clk      (clk),
                .rst      (rst),
                .port_in  (odd_in),
                .port_out (odd_out)
            );

            // end cells are already in place, just delay them.
            always_ff @(posedge clk) begin
                if (rst) begin
                    first_q <= '0;
                    last_q  <= '0;
                end else begin
                    first_q <= mixed[0];
                    last_q  <= mixed[PORT_NUB-1];
                end
            end

            assign port_out[0]          = first_q;
            assign port_out[PORT_NUB-1] = last_q;

            for (genvar i = 1; i < PORT_NUB/2; i++) begin : g_cmp
                exchange_unit u_xchg (
                    .clk    (clk),
                    .rst    (rst),
                    .a_in   (mixed[2*i-1]),
                    .b_in   (mixed[2*i]),
                    .lo_out (port_out[2*i-1]),
                    .hi_out (port_out[2*i])
                );
            end
        end
    endgenerate

endmodule

// ==== verilog/odd_even_sort.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module odd_even_sort #(
    parameter int PORT_NUB = `PORT_NUB_TOTAL
) (
    input  logic                           clk,
    input  logic                           rst,
    input  sort_pkg::cell_t [PORT_NUB-1:0] port_in,
    output sort_pkg::cell_t [PORT_NUB-1:0] port_out
);
    import sort_pkg::*;

    generate
        if (PORT_NUB == 2) begin : g_base
            exchange_unit u_xchg (
                .clk    (clk),
                .rst    (rst),
                .a_in   (port_in[0]),
                .b_in   (port_in[1]),
                .lo_out (port_out[0]),
                .hi_out (port_out[1])
            );
        end else begin : g_rec
            cell_t [PORT_NUB/2-1:0] first_in;
            cell_t [PORT_NUB/2-1:0] second_in;
            cell_t [PORT_NUB/2-1:0] first_out;
            cell_t [PORT_NUB/2-1:0] second_out;
            cell_t [PORT_NUB-1:0]   halves;

            for (genvar i = 0; i < PORT_NUB/2; i++) begin : g_split
                assign first_in[i]  = port_in[2*i];    // even ports.
                assign second_in[i] = port_in[2*i+1];  // odd ports.
            end

            odd_even_sort #(.PORT_NUB(PORT_NUB/2)) u_first (
                .clk      (clk),
                .rst      (rst),
                .port_in  (first_in),
                .port_out (first_out)
            );

            odd_even_sort #(.PORT_NUB(PORT_NUB/2)) u_second (
                .clk      (clk),
                .rst      (rst),
                .port_in  (second_in),
                .port_out (second_out)
            );

            // lower half from the first sorter, upper half from the second.
            assign halves = {second_out, first_out};

            merge_module #(.PORT_NUB(PORT_NUB)) u_merge (
                .clk      (clk),
                .rst      (rst),
                .port_in  (halves),
                .port_out (port_out)
            );
        end
    endgenerate

endmodule

// ==== verilog/contention_filter.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module contention_filter (
    input  logic                clk,
    input  logic                rst,
    input  sort_pkg::cell_vec_t cells_in,
    output sort_pkg::cell_vec_t cells_out,
    output sort_pkg::drop_cnt_t drop_count
);
    import sort_pkg::*;

    localparam int n_ports = `PORT_NUB_TOTAL;

    logic [n_ports-1:0] loser;
    cell_vec_t          kept;
    drop_cnt_t          loser_cnt;

    // sorted input puts equal destinations next to each other.
    always_comb begin
        loser[0] = 1'b0;  // first cell always wins.
        for (int i = 1; i < n_ports; i++) begin
            loser[i] = cells_in[i].valid && cells_in[i-1].valid &&
                       (cells_in[i].dst == cells_in[i-1].dst);
        end
    end

    always_comb begin
        kept      = cells_in;
        loser_cnt = '0;
        for (int i = 0; i < n_ports; i++) begin
            if (loser[i]) begin
                kept[i].valid = 1'b0;  // rest of the cell is kept.
            end
            loser_cnt = loser_cnt + drop_cnt_t'(loser[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cells_out  <= '0;
            drop_count <= '0;
        end else begin
            cells_out  <= kept;
            drop_count <= loser_cnt;
        end
    end

    // only holds if the sorter really grouped destinations.
    for (genvar i = 0; i < n_ports; i++) begin : g_chk_i
        for (genvar j = i + 1; j < n_ports; j++) begin : g_chk_j
            a_unique_dst : assert property (
                @(posedge clk) disable iff (rst)
                !(cells_out[i].valid && cells_out[j].valid &&
                  cells_out[i].dst == cells_out[j].dst)
            ) else $error("contention_filter: two valid cells share a dst.");
        end
    end

endmodule

// ==== verilog/sort_switch.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module sort_switch (
    input  logic                clk,
    input  logic                rst,
    input  sort_pkg::cell_vec_t port_in,
    output sort_pkg::cell_vec_t cells_out,
    output sort_pkg::drop_cnt_t drop_count
);
    import sort_pkg::*;

    cell_vec_t sorted;  // ascending by key, invalid cells last.

    odd_even_sort #(
        .PORT_NUB (`PORT_NUB_TOTAL)
    ) u_sort (
        .clk      (clk),
        .rst      (rst),
        .port_in  (port_in),
        .port_out (sorted)
    );

    // one more cycle to drop duplicate destinations.
    contention_filter u_filter (
        .clk        (clk),
        .rst        (rst),
        .cells_in   (sorted),
        .cells_out  (cells_out),
        .drop_count (drop_count)
    );

endmodule

// ==== test/sort_switch_tb.sv ====
`timescale 1ns/1ps
`include "sort_params.svh"

module sort_switch_tb;
    import sort_pkg::*;

    localparam int n_ports     = `PORT_NUB_TOTAL;
    localparam int n_stages    = $clog2(n_ports);
    localparam int latency     = n_stages * (n_stages + 1) / 2 + 1;
    localparam int drain_limit = 4 * latency;

    // one offered vector and what must come out of it.
    typedef struct packed {
        cell_vec_t          cells;
        logic [n_ports-1:0] dst_set;  // destinations that must appear once.
        drop_cnt_t          drops;
        int                 n_valid;
        int                 due;      // cycle at which the result is staged for checking.
    } expect_t;

    logic      clk;
    logic      rst;
    cell_vec_t port_in;
    cell_vec_t cells_out;
    drop_cnt_t drop_count;

    expect_t   pending [$];
    expect_t   exp_q;
    drop_cnt_t exp_drops;
    logic      chk_en;
    int        cyc;
    int        seed = 32'h7ac9a277;
    int        err_count = 0;
    int        test_errs = 0;
    int        pass_tests = 0;
    int        fail_tests = 0;
    logic      stop_run = 1'b0;

    assign exp_drops = exp_q.drops;

    sort_switch UUT (
        .clk        (clk),
        .rst        (rst),
        .port_in    (port_in),
        .cells_out  (cells_out),
        .drop_count (drop_count)
    );

    always #50 clk = ~clk;

    function automatic int pick_below(input int span);
        return int'($unsigned($random(seed)) % span);
    endfunction

    function automatic cell_t make_cell(input int port, input logic valid,
                                        input logic [port_w-1:0] dst);
        cell_t c;
        c.valid = valid;
        c.src   = port_w'(port);  // source is the input port.
        c.dst   = dst;
        c.data  = `DATA_WIDTH'($random(seed));
        return c;
    endfunction

    // distinct destinations, valid where the mask says so.
    function automatic cell_vec_t perm_vec(input logic [n_ports-1:0] valid_mask);
        int        order [n_ports];
        int        j;
        int        t;
        cell_vec_t v;
        for (int i = 0; i < n_ports; i++) begin
            order[i] = i;
        end
        for (int i = n_ports - 1; i > 0; i--) begin
            j        = pick_below(i + 1);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < n_ports; i++) begin
            v[i] = make_cell(i, valid_mask[i], port_w'(order[i]));
        end
        return v;
    endfunction

    function automatic cell_vec_t collide_vec();
        int        span;
        cell_vec_t v;
        span = 1 + pick_below(n_ports / 2);  // few targets, many collisions.
        for (int i = 0; i < n_ports; i++) begin
            v[i] = make_cell(i, 1'b1, port_w'(pick_below(span)));
        end
        return v;
    endfunction

    function automatic cell_vec_t random_vec();
        cell_vec_t v;
        for (int i = 0; i < n_ports; i++) begin
            v[i] = make_cell(i, pick_below(4) != 0, port_w'(pick_below(n_ports)));
        end
        return v;
    endfunction

    function automatic expect_t build_expect(input cell_vec_t v, input int due);
        expect_t e;
        e       = '0;
        e.cells = v;
        e.due   = due;
        for (int i = 0; i < n_ports; i++) begin
            if (v[i].valid) begin
                e.n_valid           = e.n_valid + 1;
                e.dst_set[v[i].dst] = 1'b1;
            end
        end
        e.drops = drop_cnt_t'(e.n_valid - $countones(e.dst_set));
        return e;
    endfunction

    function automatic logic no_valid(input cell_vec_t out);
        logic any;
        any = 1'b0;
        for (int i = 0; i < n_ports; i++) begin
            any = any | out[i].valid;
        end
        return !any;
    endfunction

    // valid outputs rise strictly in key and cover exactly the offered set.
    function automatic logic dst_order_ok(input cell_vec_t out, input expect_t e);
        logic [n_ports-1:0] seen;
        logic [key_w-1:0]   prev_key;
        logic               have_prev;
        logic               ok;
        seen      = '0;
        prev_key  = '0;
        have_prev = 1'b0;
        ok        = 1'b1;
        for (int i = 0; i < n_ports; i++) begin
            if (out[i].valid) begin
                if (have_prev && sort_key(out[i]) <= prev_key) begin
                    ok = 1'b0;
                end
                seen[out[i].dst] = 1'b1;
                prev_key         = sort_key(out[i]);
                have_prev        = 1'b1;
            end
        end
        return ok && (seen == e.dst_set);
    endfunction

    function automatic logic front_ok(input cell_vec_t out, input expect_t e);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < n_ports; i++) begin
            if (out[i].valid && i >= e.n_valid) begin
                ok = 1'b0;  // sits behind where the valid cells end.
            end
        end
        return ok;
    endfunction

    function automatic logic pairs_ok(input cell_vec_t out, input cell_vec_t sent);
        logic ok;
        logic found;
        ok = 1'b1;
        for (int i = 0; i < n_ports; i++) begin
            if (out[i].valid) begin
                found = 1'b0;
                for (int j = 0; j < n_ports; j++) begin
                    found = found | (sent[j] == out[i]);
                end
                ok = ok & found;
            end
        end
        return ok;
    endfunction

    // stage the result that is due; it meets cells_out on the next edge.
    always @(posedge clk) begin
        if (rst) begin
            cyc    <= 0;
            chk_en <= 1'b0;
        end else begin
            cyc <= cyc + 1;
            if (pending.size() > 0 && pending[0].due == cyc) begin
                exp_q  <= pending[0];
                chk_en <= 1'b1;
                pending.delete(0);
            end else begin
                chk_en <= 1'b0;
            end
        end
    end

    a_reset_idle : assert property (
        @(posedge clk) $past(rst) && !rst |-> no_valid(cells_out) && drop_count == '0
    ) else begin
        $display("ERROR at %0t: outputs not idle right after reset", $time);
        err_count = err_count + 1;
    end

    a_drop_count : assert property (
        @(posedge clk) disable iff (rst) chk_en |-> drop_count == exp_q.drops
    ) else begin
        $display("ERROR at %0t: drop_count is %0d, expected %0d",
                 $time, $sampled(drop_count), $sampled(exp_drops));
        err_count = err_count + 1;
    end

    a_dst_order : assert property (
        @(posedge clk) disable iff (rst) chk_en |-> dst_order_ok(cells_out, exp_q)
    ) else begin
        $display("ERROR at %0t: valid destinations wrong, repeated or out of order", $time);
        err_count = err_count + 1;
    end

    a_valid_front : assert property (
        @(posedge clk) disable iff (rst) chk_en |-> front_ok(cells_out, exp_q)
    ) else begin
        $display("ERROR at %0t: valid cell found after the invalid ones", $time);
        err_count = err_count + 1;
    end

    a_pairs_sent : assert property (
        @(posedge clk) disable iff (rst) chk_en |-> pairs_ok(cells_out, exp_q.cells)
    ) else begin
        $display("ERROR at %0t: valid cell carries a src/data never sent to its dst", $time);
        err_count = err_count + 1;
    end

    task automatic send(input cell_vec_t v);
        @(posedge clk);
        port_in <= v;
        pending.push_back(build_expect(v, cyc + latency));
    endtask

    task automatic end_test(input string name);
        int waited;
        int errs;
        waited = 0;
        while (pending.size() > 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() > 0) begin
            $display("test %0s: timed out, %0d results never came out", name, pending.size());
            fail_tests++;
            stop_run = 1'b1;
        end else begin
            repeat (2) @(posedge clk);  // last staged result gets checked.
            errs = err_count - test_errs;
            if (errs == 0) begin
                $display("test %0s: passed", name);
                pass_tests++;
            end else begin
                $display("test %0s: failed with %0d errors", name, errs);
                fail_tests++;
            end
        end
        test_errs = err_count;
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        port_in = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int n = 0; n < 10; n++) begin
            send('0);
        end
        end_test("idle");

        if (!stop_run) begin
            for (int n = 0; n < 20; n++) begin
                send(perm_vec('1));
            end
            end_test("permutation");
        end

        if (!stop_run) begin
            for (int n = 0; n < 40; n++) begin
                send(collide_vec());
            end
            end_test("collisions");
        end

        if (!stop_run) begin
            for (int n = 0; n < 30; n++) begin
                send(perm_vec(n_ports'($random(seed))));
            end
            for (int n = 0; n < 5; n++) begin
                send(perm_vec('0));  // empty vector with junk fields.
            end
            end_test("partial");
        end

        if (!stop_run) begin
            for (int n = 0; n < 200; n++) begin
                send(random_vec());
            end
            end_test("back_to_back");
        end

        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/sort_pkg.sv
verilog/exchange_unit.sv
verilog/merge_module.sv
verilog/odd_even_sort.sv
verilog/contention_filter.sv
verilog/sort_switch.sv
test/sort_switch_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= build.f
TB_TOP     ?= sort_switch_tb
RTL_TOP    ?= sort_switch
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$(./$(OBJ_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
